// File: all.f
+incdir+tests
hw/scope_pkg.sv
hw/cmd_receiver.sv
hw/cmd_dispatch.sv
hw/capture_writer.sv
hw/trigger_fsm.sv
hw/sample_buffer.sv
hw/reply_streamer.sv
hw/scope_top.sv
tests/tb_scope.sv

// File: hw/capture_writer.sv
//----------------------------------------
// one write every 2^downsample clocks
//----------------------------------------
module capture_writer
	import scope_pkg::*;
#(
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	input  logic              rstn,
	input  logic              i_capture_en,
	input  logic [4:0]        i_downsample,
	output logic              o_wr_stb,
	output logic [ADDR_W-1:0] o_wr_addr
);

	logic [31:0] div_cnt;
	logic [31:0] div_max;
	logic        stb_q;

	assign div_max  = (32'd1 << i_downsample) - 32'd1;
	assign o_wr_stb = stb_q & i_capture_en; // a strobe in flight is dropped on freeze

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			div_cnt   <= '0;
			stb_q     <= 1'b0;
			o_wr_addr <= '0;
		end else begin
			stb_q <= 1'b0;
			if (i_capture_en) begin
				if (div_cnt >= div_max) begin // >= covers a shrinking divider
					div_cnt <= '0;
					stb_q   <= 1'b1;
				end else begin
					div_cnt <= div_cnt + 32'd1;
				end
			end
			if (o_wr_stb)
				o_wr_addr <= o_wr_addr + 1'b1; // circular, wraps at 2^ADDR_W
		end
	end

endmodule

// File: hw/cmd_dispatch.sv
//----------------------------------------
// one command in flight at a time
// pre-offset takes the low ADDR_W bits of bytes 3-4, ADDR_W up to 16
//----------------------------------------
module cmd_dispatch
	import scope_pkg::*;
#(
	parameter int N_LANES = 4,
	parameter int ADDR_W  = 10
) (
	input  logic                       clk,
	input  logic                       rstn,
	input  cmd_word_u                  i_cmd,
	input  logic                       i_cmd_valid,
	output logic                       o_cmd_done,
	input  acq_state_e                 i_acq_state,
	input  logic [15:0]                i_event_count,
	input  logic [ADDR_W-1:0]          i_trig_addr,
	input  logic [$clog2(N_LANES)-1:0] i_trig_lane,
	output logic [7:0]                 o_trig_type,
	output sample_t                    o_lower,
	output sample_t                    o_upper,
	output logic [7:0]                 o_tot,
	output logic [15:0]                o_post_len,
	output logic                       o_arm,
	output logic                       o_readout_done,
	output logic [4:0]                 o_downsample,
	output logic                       o_start_word,
	output logic [31:0]                o_word,
	output logic                       o_start_read,
	output logic [ADDR_W-1:0]          o_read_addr,
	output logic [31:0]                o_read_len,
	input  logic                       i_reply_done
);

	logic [ADDR_W-1:0] preoffset;    // words shown before the trigger
	logic              read_pending; // current reply is a buffer read
	logic [11:0]       center;
	logic [11:0]       half_w;

	assign center = {4'd0, i_cmd.bytes[1]};
	assign half_w = {4'd0, i_cmd.bytes[2]};

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_cmd_done     <= 1'b0;
			o_arm          <= 1'b0;
			o_readout_done <= 1'b0;
			o_start_word   <= 1'b0;
			o_start_read   <= 1'b0;
			read_pending   <= 1'b0;
			o_trig_type    <= '0;
			o_lower        <= '0;
			o_upper        <= '0;
			o_tot          <= '0;
			o_post_len     <= '0;
			o_downsample   <= '0;
			preoffset      <= '0;
		end else begin
			// all strobes are single cycle
			o_cmd_done     <= i_reply_done;
			o_readout_done <= i_reply_done & read_pending;
			o_arm          <= 1'b0;
			o_start_word   <= 1'b0;
			o_start_read   <= 1'b0;
			if (i_reply_done)
				read_pending <= 1'b0;
			if (i_cmd_valid) begin
				case (i_cmd.rd.opcode)
					OP_READ: begin
						o_start_read <= 1'b1;
						read_pending <= 1'b1;
					end
					OP_ARM: begin
						o_trig_type  <= i_cmd.bytes[1];
						o_post_len   <= {i_cmd.bytes[5], i_cmd.bytes[4]};
						o_arm        <= (i_acq_state == ACQ_READY); // no re-arm mid event
						o_start_word <= 1'b1;
					end
					OP_TRIG_SET: begin
						// thresholds in adc counts from 8-bit host units
						o_lower      <= sample_t'(((center - half_w - 12'd128) << 4) + 12'd8);
						o_upper      <= sample_t'(((center + half_w - 12'd128) << 4) + 12'd8);
						preoffset    <= ADDR_W'({i_cmd.bytes[3], i_cmd.bytes[4]});
						o_tot        <= i_cmd.bytes[5];
						o_start_word <= 1'b1;
					end
					OP_DOWNSAMPLE: begin
						o_downsample <= i_cmd.bytes[1][4:0];
						o_start_word <= 1'b1;
					end
					OP_INFO: o_start_word <= 1'b1;
					default: o_cmd_done   <= 1'b1; // unknown, dropped without reply
				endcase
			end
		end
	end

	// reply payload
	always_ff @(posedge clk) begin
		if (i_cmd_valid) begin
			o_read_addr <= i_trig_addr - preoffset;
			o_read_len  <= i_cmd.rd.len; // in 32-bit words
			case (i_cmd.rd.opcode)
				OP_ARM:  o_word <= {i_event_count, 8'(i_trig_lane), i_acq_state};
				OP_INFO: o_word <= VERSION;
				default: o_word <= {24'd0, i_cmd.bytes[0]}; // echo the opcode
			endcase
		end
	end

endmodule

// File: hw/cmd_receiver.sv
//----------------------------------------
// input is blocked from a full command until the dispatcher reports done
//----------------------------------------
module cmd_receiver
	import scope_pkg::*;
(
	input  logic       clk,
	input  logic       rstn,
	input  logic       i_rx_valid,
	input  logic [7:0] i_rx_data,
	output logic       o_rx_ready,
	input  logic       i_cmd_done,
	output cmd_word_u  o_cmd,
	output logic       o_cmd_valid
);

	logic [2:0] byte_cnt; // position of the next byte
	logic       busy;     // command handed over, waiting for done
	logic       rx_fire;

	assign o_rx_ready = ~busy;
	assign rx_fire    = i_rx_valid & o_rx_ready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt    <= '0;
			busy        <= 1'b0;
			o_cmd_valid <= 1'b0;
		end else begin
			o_cmd_valid <= 1'b0;
			if (rx_fire) begin
				byte_cnt <= byte_cnt + 3'd1; // wraps back to 0 after byte 7
				if (byte_cnt == 3'd7) begin
					busy        <= 1'b1;
					o_cmd_valid <= 1'b1;
				end
			end
			if (i_cmd_done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rx_fire)
			o_cmd.bytes[byte_cnt] <= i_rx_data;
	end

endmodule

// File: hw/reply_streamer.sv
//----------------------------------------
// next ram word is fetched only after the current one is fully sent
// a zero-length read finishes without any output word
//----------------------------------------
module reply_streamer
	import scope_pkg::*;
#(
	parameter int N_LANES = 4,
	parameter int ADDR_W  = 10
) (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  i_start_word,
	input  logic [31:0]           i_word,
	input  logic                  i_start_read,
	input  logic [ADDR_W-1:0]     i_read_addr,
	input  logic [31:0]           i_read_len,
	output logic [ADDR_W-1:0]     o_rd_addr,
	input  sample_t [N_LANES-1:0] i_rd_data,
	output logic                  o_tx_valid,
	output logic [31:0]           o_tx_data,
	output logic                  o_tx_last,
	input  logic                  i_tx_ready,
	output logic                  o_done
);

	localparam int PAIRS  = N_LANES / 2;
	localparam int PAIR_W = (PAIRS > 1) ? $clog2(PAIRS) : 1;

	typedef enum logic [1:0] {S_IDLE, S_ADDR, S_LOAD, S_SEND} st_e;

	st_e                   state;
	logic [31:0]           remaining; // words still to go, current one included
	logic [PAIR_W-1:0]     pair;      // lane pair being sent
	sample_t [N_LANES-1:0] line;      // ram word being sent
	logic                  accept;

	assign accept = o_tx_valid & i_tx_ready;

	// lane 2k in the low half, lane 2k+1 in the high half
	function automatic logic [31:0] pack_pair(sample_t [N_LANES-1:0] w, int k);
		return {{(16-SAMPLE_W){1'b0}}, w[2*k+1], {(16-SAMPLE_W){1'b0}}, w[2*k]};
	endfunction

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= S_IDLE;
			remaining  <= '0;
			pair       <= '0;
			o_rd_addr  <= '0;
			o_tx_valid <= 1'b0;
			o_tx_last  <= 1'b0;
			o_done     <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (i_start_word) begin
						remaining  <= 32'd1;
						o_tx_valid <= 1'b1;
						o_tx_last  <= 1'b1;
						state      <= S_SEND;
					end else if (i_start_read) begin
						remaining <= i_read_len;
						o_rd_addr <= i_read_addr;
						if (i_read_len == 32'd0)
							o_done <= 1'b1;
						else
							state <= S_ADDR;
					end
				end
				S_ADDR: state <= S_LOAD; // ram latches the address now
				S_LOAD: begin
					pair       <= '0;
					o_tx_valid <= 1'b1;
					o_tx_last  <= (remaining == 32'd1);
					state      <= S_SEND;
				end
				S_SEND: begin
					if (accept) begin
						remaining <= remaining - 32'd1;
						if (remaining == 32'd1) begin // final word taken
							o_tx_valid <= 1'b0;
							o_tx_last  <= 1'b0;
							o_done     <= 1'b1;
							state      <= S_IDLE;
						end else if (pair == PAIR_W'(PAIRS - 1)) begin
							o_tx_valid <= 1'b0;
							o_rd_addr  <= o_rd_addr + 1'b1; // circular like the writer
							state      <= S_ADDR;
						end else begin
							pair      <= pair + 1'b1;
							o_tx_last <= (remaining == 32'd2);
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// data path, held while waiting for ready
	always_ff @(posedge clk) begin
		if (state == S_IDLE && i_start_word) begin
			o_tx_data <= i_word;
		end else if (state == S_LOAD) begin
			line      <= i_rd_data;
			o_tx_data <= pack_pair(i_rd_data, 0);
		end else if (state == S_SEND && accept && pair != PAIR_W'(PAIRS - 1)) begin
			o_tx_data <= pack_pair(line, int'(pair) + 1);
		end
	end

endmodule

// File: hw/sample_buffer.sv
//----------------------------------------
// read data appears one clock after the address
//----------------------------------------
module sample_buffer
	import scope_pkg::*;
#(
	parameter int N_LANES = 4,
	parameter int ADDR_W  = 10
) (
	input  logic                  clk,
	input  logic                  i_wr_en,
	input  logic [ADDR_W-1:0]     i_wr_addr,
	input  sample_t [N_LANES-1:0] i_wr_data,
	input  logic [ADDR_W-1:0]     i_rd_addr,
	output sample_t [N_LANES-1:0] o_rd_data
);

	sample_t [N_LANES-1:0] mem [2**ADDR_W]; // one word per capture strobe

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

// File: hw/scope_pkg.sv
//----------------------------------------
// shared types of the digitizer core
// opcode and state values match the host software
//----------------------------------------
package scope_pkg;

	localparam int          SAMPLE_W = 12;     // adc resolution
	localparam logic [31:0] VERSION  = 32'd18; // firmware version, returned by OP_INFO

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	typedef enum logic [7:0] {
		OP_READ       = 8'd0, // stream the sample buffer
		OP_ARM        = 8'd1, // arm and poll status
		OP_INFO       = 8'd2, // version readback
		OP_TRIG_SET   = 8'd8, // thresholds, pre-offset, time over threshold
		OP_DOWNSAMPLE = 8'd9  // write strobe divider
	} opcode_e;

	typedef enum logic [7:0] {
		ACQ_READY     = 8'd0,
		ACQ_RISE_ARM  = 8'd1,   // waiting below the lower threshold
		ACQ_RISE_FIRE = 8'd2,   // counting above the upper threshold
		ACQ_FALL_ARM  = 8'd3,
		ACQ_FALL_FIRE = 8'd4,
		ACQ_POST      = 8'd250, // taking post-trigger words
		ACQ_DONE      = 8'd251  // frozen until read out
	} acq_state_e;

	// one 8-byte command, byte 0 is always the opcode
	typedef union packed {
		logic [7:0][7:0] bytes; // bytes[k] arrived k-th
		struct packed {
			logic [31:0] len;   // bytes 4-7, little endian
			logic [23:0] pad;
			opcode_e     opcode;
		} rd;
	} cmd_word_u;

endpackage

// File: hw/scope_top.sv
//----------------------------------------
// digitizer core, samples arrive parallel in the clk domain
// N_LANES must be even
//----------------------------------------
module scope_top
	import scope_pkg::*;
#(
	parameter int N_LANES = 4,
	parameter int ADDR_W  = 10
) (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  i_rx_valid,
	input  logic [7:0]            i_rx_data,
	output logic                  o_rx_ready,
	output logic                  o_tx_valid,
	output logic [31:0]           o_tx_data,
	output logic                  o_tx_last,
	input  logic                  i_tx_ready,
	input  sample_t [N_LANES-1:0] i_samples
);

	localparam int LANE_W = $clog2(N_LANES);

	// -------- command side --------
	cmd_word_u         cmd;
	logic              cmd_valid, cmd_done;
	logic              start_word, start_read, reply_done;
	logic [31:0]       word, read_len;
	logic [ADDR_W-1:0] read_addr, rd_addr;

	// -------- acquisition side --------
	acq_state_e            acq_state;
	logic [15:0]           event_count, post_len;
	logic [ADDR_W-1:0]     trig_addr, wr_addr;
	logic [LANE_W-1:0]     trig_lane;
	logic [7:0]            trig_type, tot;
	sample_t               lower, upper;
	logic                  arm, readout_done, capture_en, wr_stb;
	logic [4:0]            downsample;
	sample_t [N_LANES-1:0] rd_data;

	cmd_receiver u_rx (
		.clk, .rstn, .i_rx_valid, .i_rx_data, .o_rx_ready,
		.i_cmd_done(cmd_done), .o_cmd(cmd), .o_cmd_valid(cmd_valid)
	);

	cmd_dispatch #(.N_LANES(N_LANES), .ADDR_W(ADDR_W)) u_disp (
		.clk, .rstn, .i_cmd(cmd), .i_cmd_valid(cmd_valid), .o_cmd_done(cmd_done),
		.i_acq_state(acq_state), .i_event_count(event_count),
		.i_trig_addr(trig_addr), .i_trig_lane(trig_lane),
		.o_trig_type(trig_type), .o_lower(lower), .o_upper(upper), .o_tot(tot),
		.o_post_len(post_len), .o_arm(arm), .o_readout_done(readout_done),
		.o_downsample(downsample), .o_start_word(start_word), .o_word(word),
		.o_start_read(start_read), .o_read_addr(read_addr), .o_read_len(read_len),
		.i_reply_done(reply_done)
	);

	capture_writer #(.ADDR_W(ADDR_W)) u_wr (
		.clk, .rstn, .i_capture_en(capture_en), .i_downsample(downsample),
		.o_wr_stb(wr_stb), .o_wr_addr(wr_addr)
	);

	trigger_fsm #(.N_LANES(N_LANES), .ADDR_W(ADDR_W)) u_trig (
		.clk, .rstn, .i_samples, .i_wr_stb(wr_stb), .i_wr_addr(wr_addr),
		.i_trig_type(trig_type), .i_lower(lower), .i_upper(upper), .i_tot(tot),
		.i_post_len(post_len), .i_arm(arm), .i_readout_done(readout_done),
		.o_capture_en(capture_en), .o_acq_state(acq_state),
		.o_event_count(event_count), .o_trig_addr(trig_addr), .o_trig_lane(trig_lane)
	);

	sample_buffer #(.N_LANES(N_LANES), .ADDR_W(ADDR_W)) u_buf (
		.clk, .i_wr_en(wr_stb), .i_wr_addr(wr_addr), .i_wr_data(i_samples),
		.i_rd_addr(rd_addr), .o_rd_data(rd_data)
	);

	reply_streamer #(.N_LANES(N_LANES), .ADDR_W(ADDR_W)) u_tx (
		.clk, .rstn, .i_start_word(start_word), .i_word(word),
		.i_start_read(start_read), .i_read_addr(read_addr), .i_read_len(read_len),
		.o_rd_addr(rd_addr), .i_rd_data(rd_data),
		.o_tx_valid, .o_tx_data, .o_tx_last, .i_tx_ready, .o_done(reply_done)
	);

endmodule

// File: hw/trigger_fsm.sv
//----------------------------------------
// threshold levels are checked every clock, not only on write strobes
// type 1 rising, type 2 falling, any other type fires at once
//----------------------------------------
module trigger_fsm
	import scope_pkg::*;
#(
	parameter int N_LANES = 4,
	parameter int ADDR_W  = 10
) (
	input  logic                       clk,
	input  logic                       rstn,
	input  sample_t [N_LANES-1:0]      i_samples,
	input  logic                       i_wr_stb,
	input  logic [ADDR_W-1:0]          i_wr_addr,
	input  logic [7:0]                 i_trig_type,
	input  sample_t                    i_lower,
	input  sample_t                    i_upper,
	input  logic [7:0]                 i_tot,
	input  logic [15:0]                i_post_len,
	input  logic                       i_arm,
	input  logic                       i_readout_done,
	output logic                       o_capture_en,
	output acq_state_e                 o_acq_state,
	output logic [15:0]                o_event_count,
	output logic [ADDR_W-1:0]          o_trig_addr,
	output logic [$clog2(N_LANES)-1:0] o_trig_lane
);

	localparam int LANE_W = $clog2(N_LANES);

	logic              any_low;
	logic              any_high;
	logic [LANE_W-1:0] low_lane;  // lowest lane below the lower threshold
	logic [LANE_W-1:0] high_lane; // lowest lane above the upper threshold
	logic [7:0]        tot_cnt;
	logic [15:0]       post_cnt;

	assign o_capture_en = (o_acq_state != ACQ_DONE);

	always_comb begin
		any_low   = 1'b0;
		any_high  = 1'b0;
		low_lane  = '0;
		high_lane = '0;
		for (int k = N_LANES - 1; k >= 0; k--) begin // downward so the lowest lane wins
			if (i_samples[k] < i_lower) begin
				any_low  = 1'b1;
				low_lane = LANE_W'(k);
			end
			if (i_samples[k] > i_upper) begin
				any_high  = 1'b1;
				high_lane = LANE_W'(k);
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_acq_state   <= ACQ_READY;
			o_event_count <= '0;
			o_trig_addr   <= '0;
			o_trig_lane   <= '0;
			tot_cnt       <= '0;
			post_cnt      <= '0;
		end else begin
			case (o_acq_state)
				ACQ_READY: begin
					tot_cnt  <= '0;
					post_cnt <= '0;
					if (i_arm) begin
						if (i_trig_type == 8'd1)
							o_acq_state <= ACQ_RISE_ARM;
						else if (i_trig_type == 8'd2)
							o_acq_state <= ACQ_FALL_ARM;
						else begin // free run
							o_trig_addr <= i_wr_addr;
							o_trig_lane <= '0;
							o_acq_state <= ACQ_POST;
						end
					end
				end
				ACQ_RISE_ARM: if (any_low) o_acq_state <= ACQ_RISE_FIRE;
				ACQ_FALL_ARM: if (any_high) o_acq_state <= ACQ_FALL_FIRE;
				ACQ_RISE_FIRE, ACQ_FALL_FIRE: begin
					// time over threshold on the far side
					if ((o_acq_state == ACQ_RISE_FIRE) ? any_high : any_low) begin
						tot_cnt <= tot_cnt + 8'd1;
						if (tot_cnt >= i_tot) begin
							o_trig_addr <= i_wr_addr;
							o_trig_lane <= (o_acq_state == ACQ_RISE_FIRE) ? high_lane : low_lane;
							o_acq_state <= ACQ_POST;
						end
					end
				end
				ACQ_POST: begin
					if (post_cnt >= i_post_len) begin
						o_event_count <= o_event_count + 16'd1;
						o_acq_state   <= ACQ_DONE;
					end else if (i_wr_stb) begin
						post_cnt <= post_cnt + 16'd1;
					end
				end
				ACQ_DONE: if (i_readout_done) o_acq_state <= ACQ_READY;
				default: o_acq_state <= ACQ_READY;
			endcase
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# compile and run the scope testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_scope -f all.f \
	&& out="$(./obj_dir/Vtb_scope)" \
	&& printf '%s\n' "$out" \
	&& printf '%s\n' "$out" | grep -qx 'NO ERRORS' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tests/tb_scope_util.svh
//----------------------------------------
// helpers included inside tb_scope
// they use its clk, rx ports, reply queues and error counters
//----------------------------------------
`ifndef TB_SCOPE_UTIL_SVH
`define TB_SCOPE_UTIL_SVH

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// arm command with the type in byte 1 and the post length in bytes 4-5
function automatic logic [63:0] arm_cmd(input logic [7:0] ttype, input logic [15:0] plen);
	return {16'd0, plen, 16'd0, ttype, 8'd1};
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	n_checks++;
	assert (got === exp) else begin
		n_value_err++;
		$display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
	end
endtask

task automatic check_true(input logic cond, input string what);
	n_checks++;
	assert (cond) else begin
		n_other_err++;
		$display("at %0t: %s", $time, what);
	end
endtask

// byte 0 first and valid held until the receiver takes each byte
task automatic send_cmd(input logic [63:0] cmd);
	int k;
	k = 0;
	while (k < 8) begin
		@(negedge clk);
		i_rx_valid = 1'b1;
		i_rx_data  = cmd[8*k +: 8];
		if (o_rx_ready)
			k++; // taken on the coming rising edge
	end
	@(negedge clk);
	i_rx_valid = 1'b0;
	check_true(!o_rx_ready, "o_rx_ready stayed high after the eighth byte"); // busy until done
endtask

// returns once the word with last is in the queue
task automatic collect_reply();
	while (last_q.size() == 0 || !last_q[$])
		@(posedge clk);
endtask

task automatic word_cmd(input logic [63:0] cmd, output logic [31:0] word);
	send_cmd(cmd);
	collect_reply();
	check_true(reply_q.size() == 1, "single-word reply did not come as exactly one word");
	word = reply_q[$];
	reply_q.delete();
	last_q.delete();
endtask

task automatic poll_until_done(input logic [7:0] ttype, output logic [31:0] status);
	int n;
	n      = 0;
	status = '0;
	while (status[7:0] != ACQ_DONE_VAL && n < MAX_POLLS) begin
		word_cmd(arm_cmd(ttype, 16'(POST_LEN)), status); // same type and length so nothing re-arms
		n++;
	end
	check_value("status state", 32'(status[7:0]), ACQ_DONE_VAL);
endtask

`endif

// File: tests/tb_scope.sv
//----------------------------------------
// scope_top driven with a cycle stamp on every lane
// so that buffer reads can be checked without a model
//----------------------------------------
module tb_scope;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_LANES       = 4;
	localparam int ADDR_W        = 10;
	localparam int VERSION       = 18;
	localparam int DS            = 1;   // downsample exponent
	localparam int POST_LEN      = 8;   // post-trigger ram words
	localparam int READ_N        = 12;  // read length in 32-bit words
	localparam int TOT           = 5;   // time over threshold
	localparam int CENTER        = 128;
	localparam int HALF_W        = 16;
	localparam int LOW_VAL       = -500; // under every lower threshold used here
	localparam int MAX_POLLS     = 40;
	localparam int ACQ_READY_VAL = 0;
	localparam int ACQ_DONE_VAL  = 251;
	// reset plus every command at 8 bytes and a reply under random ready
	localparam int TIMEOUT = 16 + (8 + 2 * MAX_POLLS) * 64 + READ_N * 32 + 400;

	logic                     clk;
	logic                     rstn;
	logic                     i_rx_valid;
	logic [7:0]               i_rx_data;
	logic                     o_rx_ready;
	logic                     o_tx_valid;
	logic [31:0]              o_tx_data;
	logic                     o_tx_last;
	logic                     i_tx_ready;
	logic [N_LANES-1:0][11:0] i_samples;

	logic [31:0] lfsr;
	int          cyc;          // rising edges since time 0
	int          mode;         // 0 stamp, 1 all low, 2 high pattern
	int          n_checks;
	int          n_value_err;
	int          n_other_err;
	logic [31:0] reply_q[$];   // accepted reply words
	logic        last_q[$];
	logic        held;         // word offered and refused on the last edge
	logic [31:0] held_data;
	logic        held_last;

	scope_top #(.N_LANES(N_LANES), .ADDR_W(ADDR_W)) UUT (
		.clk, .rstn, .i_rx_valid, .i_rx_data, .o_rx_ready,
		.o_tx_valid, .o_tx_data, .o_tx_last, .i_tx_ready, .i_samples
	);

	`include "tb_scope_util.svh"

	// lane 0 stays quiet while the others rise above the upper threshold
	function automatic logic [11:0] high_value(input int k);
		return (k == 0) ? 12'd0 : 12'(400 + 100 * k);
	endfunction

	function automatic int expected_lane();
		int upper;
		upper = (CENTER + HALF_W - 128) * 16 + 8; // threshold in adc counts
		for (int k = 0; k < N_LANES; k++)
			if ($signed(high_value(k)) > upper)
				return k;
		return -1;
	endfunction

	task automatic check_read();
		logic [10:0] base;
		logic [10:0] prev_base;
		logic [10:0] lo;
		logic [10:0] hi;
		logic [10:0] hi_exp;
		logic [10:0] step;
		int          k;
		check_value("read word count", 32'(reply_q.size()), READ_N);
		prev_base = '0;
		for (int j = 0; j < reply_q.size(); j++) begin
			k      = j % (N_LANES / 2);       // lane pair inside the ram word
			lo     = reply_q[j][10:0];
			hi     = reply_q[j][26:16];
			hi_exp = lo + 11'd1;
			base   = lo - 11'(2 * k);         // stamp of lane 0
			step   = base - prev_base;        // mod 2048
			check_value("o_tx_data pad bits", reply_q[j] & 32'hF800_F800, 32'd0);
			check_value("o_tx_data high lane", 32'(hi), 32'(hi_exp));
			check_value("o_tx_last", 32'(last_q[j]), 32'(j == READ_N - 1));
			if (k == 0 && j > 0)
				check_value("ram word step", 32'(step), N_LANES << DS);
			else if (k != 0)
				check_value("lane pair base", 32'(base), 32'(prev_base));
			prev_base = base;
		end
		reply_q.delete();
		last_q.delete();
	endtask

	task automatic report_counts();
		$display("checks %0d, value errors %0d, other errors %0d",
			n_checks, n_value_err, n_other_err);
	endtask

	always #2 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT) begin
			n_other_err++;
			$display("timeout: test did not finish within %0d cycles", TIMEOUT);
			report_counts();
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// inputs and reply monitor on the falling edge
	always @(negedge clk) begin
		for (int k = 0; k < N_LANES; k++) begin
			case (mode)
				1:       i_samples[k] = 12'(LOW_VAL);
				2:       i_samples[k] = high_value(k);
				default: i_samples[k] = 12'((cyc * N_LANES + k) % 2048); // cycle stamp
			endcase
		end
		if (held) begin // refused word must stay put
			check_true(o_tx_valid, "o_tx_valid dropped before the word was taken");
			check_value("o_tx_data held", o_tx_data, held_data);
			check_value("o_tx_last held", 32'(o_tx_last), 32'(held_last));
		end
		lfsr       = lfsr_step(lfsr);
		i_tx_ready = lfsr[0];
		if (o_tx_valid && i_tx_ready) begin // moves on the next rising edge
			reply_q.push_back(o_tx_data);
			last_q.push_back(o_tx_last);
		end
		held      = o_tx_valid && !i_tx_ready;
		held_data = o_tx_data;
		held_last = o_tx_last;
	end

	initial begin
		logic [31:0] word;
		logic [31:0] status;
		clk        = 1'b0;
		rstn       = 1'b0;
		i_rx_valid = 1'b0;
		i_rx_data  = '0;
		i_tx_ready = 1'b0;
		i_samples  = '0;
		lfsr       = 32'h115c3a92;
		mode       = 0;
		held       = 1'b0;
		repeat (16) @(negedge clk);
		rstn = 1'b1;
		repeat (4) @(negedge clk);
		check_value("o_rx_ready", 32'(o_rx_ready), 32'd1);

		// version comes as one word with last and nothing after it
		word_cmd(64'd2, word);
		check_value("version", word, VERSION);
		repeat (20) @(posedge clk);
		check_true(reply_q.size() == 0, "extra word after the version reply");

		word_cmd({48'd0, 8'(DS), 8'd9}, word);
		check_value("downsample echo", word, 32'd9);

		// free-running event
		poll_until_done(8'd0, status);
		check_value("event count", 32'(status[31:16]), 32'd1);
		check_value("trigger lane", 32'(status[15:8]), 32'd0);

		// readout under random back-pressure
		send_cmd({32'(READ_N), 32'd0});
		collect_reply();
		check_read();
		repeat (20) @(posedge clk);
		check_true(reply_q.size() == 0, "words arrived after the last read word");

		// rising trigger for the second event
		word_cmd({16'd0, 8'(TOT), 16'd0, 8'(HALF_W), 8'(CENTER), 8'd8}, word);
		repeat (2) @(posedge clk);
		mode = 1;
		repeat (4) @(posedge clk);
		word_cmd(arm_cmd(8'd1, 16'(POST_LEN)), status); // reports the state before arming
		check_value("state after readout", 32'(status[7:0]), ACQ_READY_VAL);
		check_value("event count", 32'(status[31:16]), 32'd1);
		repeat (4) @(posedge clk);
		mode = 2;
		repeat (TOT + 4) @(posedge clk);
		mode = 0;
		poll_until_done(8'd1, status);
		check_value("event count", 32'(status[31:16]), 32'd2);
		check_value("trigger lane", 32'(status[15:8]), expected_lane());

		repeat (10) @(posedge clk);
		report_counts();
		if (n_value_err + n_other_err == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
